// File: cam_lane.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_switch_config.svh"

module cam_lane #(
    parameter int LANE_ID = 1
) (
    input  logic               main_clk,
    input  logic               rstn,
    input  video_pkg::pixel_t  i_cam_pix,
    input  video_pkg::cam_id_t i_cam_sel,
    input  logic               i_rd_en,
    output video_pkg::rgb_t    o_rgb
);

    import video_pkg::*;

    localparam int            AW       = (`LANE_DEPTH > 1) ? $clog2(`LANE_DEPTH) : 1;
    localparam logic [AW-1:0] LAST_PTR = AW'(`LANE_DEPTH - 1);
    localparam logic [AW:0]   FULL_CNT = (AW + 1)'(`LANE_DEPTH);

    rgb_t          mem [`LANE_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          clear;
    logic          empty;
    logic          full;
    logic          wr_ok;
    logic          rd_ok;

    // ************************************************************
    // FIFO control
    // ************************************************************
    assign clear = i_cam_pix.vsync || (i_cam_sel != cam_id_t'(LANE_ID));
    assign empty = (count == '0);
    assign full  = (count == FULL_CNT);
    assign wr_ok = i_cam_pix.de && !full && !clear;   // full drops the word
    assign rd_ok = i_rd_en && !empty && !clear;

    always_ff @(posedge main_clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_cam_pix.rgb;
        end
    end

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (clear) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // first word falls through, white when dry
    assign o_rgb = empty ? '1 : mem[rd_ptr];

endmodule : cam_lane

`default_nettype wire

// File: cam_switch_config.svh
`ifndef CAM_SWITCH_CONFIG_SVH
`define CAM_SWITCH_CONFIG_SVH

// ************************************************************
// frame geometry, sets coordinate widths only
// ************************************************************
`define H_ACT 1280
`define V_ACT 720

// ************************************************************
// camera path
// ************************************************************
`define CAM_NUM 4     // camera 0 is the main stream
`define PIX_DELAY 5   // main stream delay stages
`define LANE_DEPTH 16 // must exceed PIX_DELAY plus camera skew

// key debounce, stable cycles per edge
`define KEY_TICK 5

`endif

// File: cam_switch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_switch_config.svh"

module cam_switch_top (
    input  logic              main_clk,
    input  logic              rstn,
    input  video_pkg::pixel_t i_cam_pix [`CAM_NUM],
    input  logic              i_key,
    output video_pkg::pixel_t o_pix
);

    import video_pkg::*;

    logic    toggle_stb;
    cam_id_t cam_sel;
    pixel_t  main_dly;
    rgb_t    lane_rgb [1:`CAM_NUM-1];

    // ************************************************************
    // camera selection
    // ************************************************************
    key_toggle u_key_toggle (
        .main_clk     (main_clk  ),
        .rstn         (rstn      ),
        .i_key        (i_key     ),
        .o_toggle_stb (toggle_stb)
    );

    frame_selector u_frame_selector (
        .main_clk      (main_clk          ),
        .rstn          (rstn              ),
        .i_toggle_stb  (toggle_stb        ),
        .i_main_vsync  (i_cam_pix[0].vsync),
        .o_cam_sel     (cam_sel           ),
        .o_frame_start (                  )
    );

    // ************************************************************
    // pixel path
    // ************************************************************
    pixel_delay u_pixel_delay (
        .main_clk (main_clk    ),
        .rstn     (rstn        ),
        .i_pix    (i_cam_pix[0]),
        .o_pix    (main_dly    )
    );

    for (genvar k = 1; k < `CAM_NUM; k++) begin : g_lane
        cam_lane #(
            .LANE_ID (k)
        ) u_cam_lane (
            .main_clk  (main_clk    ),
            .rstn      (rstn        ),
            .i_cam_pix (i_cam_pix[k]),
            .i_cam_sel (cam_sel     ),
            .i_rd_en   (main_dly.de ),   // drained in step with main
            .o_rgb     (lane_rgb[k] )
        );
    end

    output_mux u_output_mux (
        .main_clk   (main_clk),
        .rstn       (rstn    ),
        .i_main_pix (main_dly),
        .i_lane_rgb (lane_rgb),
        .i_cam_sel  (cam_sel ),
        .o_pix      (o_pix   )
    );

endmodule : cam_switch_top

`default_nettype wire

// File: frame_selector.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_switch_config.svh"

module frame_selector (
    input  logic               main_clk,
    input  logic               rstn,
    input  logic               i_toggle_stb,
    input  logic               i_main_vsync,
    output video_pkg::cam_id_t o_cam_sel,
    output logic               o_frame_start
);

    import video_pkg::*;

    localparam cam_id_t LAST_CAM = cam_id_t'(`CAM_NUM - 1);

    logic    vsync_d1;
    logic    vsync_d2;
    cam_id_t pending;

    // second high cycle of vsync, once per frame
    assign o_frame_start = i_main_vsync && vsync_d1 && !vsync_d2;

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            vsync_d1  <= 1'b0;
            vsync_d2  <= 1'b0;
            pending   <= '0;
            o_cam_sel <= '0;
        end else begin
            vsync_d1 <= i_main_vsync;
            vsync_d2 <= vsync_d1;
            if (i_toggle_stb) begin
                pending <= (pending == LAST_CAM) ? '0 : pending + 1'b1;
            end
            if (o_frame_start) begin
                o_cam_sel <= pending;   // never split a frame
            end
        end
    end

endmodule : frame_selector

`default_nettype wire

// File: key_toggle.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_switch_config.svh"

module key_toggle (
    input  logic main_clk,
    input  logic rstn,
    input  logic i_key,
    output logic o_toggle_stb
);

    import video_pkg::*;

    localparam int              CNT_W    = $clog2(`KEY_TICK + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`KEY_TICK - 1);

    key_state_t       state;
    logic [CNT_W-1:0] cnt;   // prior consecutive samples in the new level
    logic             stable_done;

    assign stable_done = (cnt == CNT_LAST);

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            state        <= KEY_IDLE;
            cnt          <= '0;
            o_toggle_stb <= 1'b0;
        end else begin
            o_toggle_stb <= 1'b0;
            case (state)
                KEY_IDLE, KEY_PRESS_WAIT: begin
                    if (!i_key) begin
                        state <= KEY_IDLE;   // bounce, start over
                        cnt   <= '0;
                    end else if (stable_done) begin
                        state        <= KEY_HELD;
                        cnt          <= '0;
                        o_toggle_stb <= 1'b1;   // one step per press
                    end else begin
                        state <= KEY_PRESS_WAIT;
                        cnt   <= cnt + 1'b1;
                    end
                end
                KEY_HELD, KEY_RELEASE_WAIT: begin
                    if (i_key) begin
                        state <= KEY_HELD;
                        cnt   <= '0;
                    end else if (stable_done) begin
                        state <= KEY_IDLE;   // re-armed
                        cnt   <= '0;
                    end else begin
                        state <= KEY_RELEASE_WAIT;
                        cnt   <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= KEY_IDLE;
                    cnt   <= '0;
                end
            endcase
        end
    end

endmodule : key_toggle

`default_nettype wire

// File: output_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_switch_config.svh"

module output_mux (
    input  logic               main_clk,
    input  logic               rstn,
    input  video_pkg::pixel_t  i_main_pix,
    input  video_pkg::rgb_t    i_lane_rgb [1:`CAM_NUM-1],
    input  video_pkg::cam_id_t i_cam_sel,
    output video_pkg::pixel_t  o_pix
);

    import video_pkg::*;

    pixel_t pix_next;

    // timing always from the main camera
    always_comb begin
        pix_next = i_main_pix;
        if (i_cam_sel != '0) begin
            pix_next.rgb = i_lane_rgb[i_cam_sel];
        end
    end

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            o_pix <= '0;
        end else begin
            o_pix <= pix_next;
        end
    end

endmodule : output_mux

`default_nettype wire

// File: pixel_delay.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_switch_config.svh"

module pixel_delay (
    input  logic              main_clk,
    input  logic              rstn,
    input  video_pkg::pixel_t i_pix,
    output video_pkg::pixel_t o_pix
);

    import video_pkg::*;

    pixel_t pipe [`PIX_DELAY];

    always_ff @(posedge main_clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `PIX_DELAY; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0] <= i_pix;
            for (int i = 1; i < `PIX_DELAY; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    // lanes fill while the main word is in flight
    assign o_pix = pipe[`PIX_DELAY-1];

endmodule : pixel_delay

`default_nettype wire

// File: project.f
+incdir+.
video_pkg.sv
key_toggle.sv
frame_selector.sv
pixel_delay.sv
cam_lane.sv
output_mux.sv
cam_switch_top.sv
tb_cam_switch.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_cam_switch -o sim_cam_switch
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit $status
fi

./obj_dir/sim_cam_switch
status=$?
if [ $status -ne 0 ]; then
    echo "run failed"
    exit $status
fi

exit 0

// File: tb_cam_switch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cam_switch_config.svh"

module tb_cam_switch;

    import video_pkg::*;

    localparam int HIST  = `PIX_DELAY + 2;   // one slot ahead of the sampling edge
    localparam int LINES = 3;
    localparam int PIXW  = 8;

    logic    main_clk;
    logic    rstn;
    pixel_t  cam_pix [`CAM_NUM];
    logic    i_key;
    pixel_t  o_pix;

    pixel_t  hist [HIST][`CAM_NUM];
    cam_id_t hist_sel [HIST];
    logic    hist_dark [HIST];
    cam_id_t tag_sel;
    logic    tag_dark;
    cam_id_t frame_sel;
    int      presses;
    int      fill;
    logic    mon_on;
    string   test_name;

    cam_switch_top i_cam_switch_top (
        .main_clk  (main_clk),
        .rstn      (rstn    ),
        .i_cam_pix (cam_pix ),
        .i_key     (i_key   ),
        .o_pix     (o_pix   )
    );

    initial begin
        main_clk = 1'b0;
        forever #10 main_clk = ~main_clk;
    end

    // ************************************************************
    // compare tasks
    // ************************************************************
    task automatic check_pix(input pixel_t exp_pix, input pixel_t act_pix);
        if (exp_pix !== act_pix) begin
            $display("MISMATCH %s expected %h actual %h", test_name, exp_pix, act_pix);
            $display("Simulation failed");
            $fatal(1, "pixel compare failed");
        end
    endtask

    task automatic check_cam(input cam_id_t exp_id, input cam_id_t act_id);
        if (exp_id !== act_id) begin
            $display("MISMATCH %s expected %0d actual %0d", test_name, exp_id, act_id);
            $display("Simulation failed");
            $fatal(1, "camera compare failed");
        end
    endtask

    // ************************************************************
    // reference model and output monitor
    // ************************************************************
    always @(negedge main_clk) begin : monitor
        pixel_t src;
        pixel_t expd;
        int     hit;
        if (mon_on) begin
            for (int d = HIST - 1; d > 0; d--) begin
                hist[d]      = hist[d-1];
                hist_sel[d]  = hist_sel[d-1];
                hist_dark[d] = hist_dark[d-1];
            end
            hist[0]      = cam_pix;
            hist_sel[0]  = tag_sel;
            hist_dark[0] = tag_dark;
            if (fill < HIST) begin
                fill++;
            end else begin
                src  = hist[HIST-1][0];
                expd = src;
                if (!src.de) begin
                    if ((hist_sel[HIST-1] != '0) || (tag_sel != '0)) begin
                        expd.rgb = o_pix.rgb;   // lane colour is free in blanking
                    end
                end else if (hist_dark[HIST-1]) begin
                    expd.rgb = '1;
                end else begin
                    expd.rgb = hist[HIST-1][hist_sel[HIST-1]].rgb;
                    hit = -1;
                    for (int j = `CAM_NUM - 1; j >= 0; j--) begin
                        if (hist[HIST-1][j].rgb == o_pix.rgb) hit = j;
                    end
                    if (hit < 0) begin
                        $display("Simulation failed");
                        $fatal(1, "output colour in %s matches no camera", test_name);
                    end
                    check_cam(hist_sel[HIST-1], cam_id_t'(hit));
                end
                check_pix(expd, o_pix);
            end
        end
    end

    // ************************************************************
    // stimulus
    // ************************************************************
    task automatic drive_cycle(input logic vs, input logic hs, input logic de, input int x,
                               input int y, input logic key, input int dark_cam);
        pixel_t p;
        @(posedge main_clk);
        for (int j = 0; j < `CAM_NUM; j++) begin
            p.vsync = vs;
            p.hsync = hs;
            p.de    = de && (j != dark_cam);
            p.rgb   = de ? rgb_t'($urandom) : '0;
            p.x     = X_W'(x);
            p.y     = Y_W'(y);
            cam_pix[j] <= p;
        end
        i_key    <= key;
        tag_sel  <= frame_sel;
        tag_dark <= (dark_cam > 0) && (int'(frame_sel) == dark_cam);
    endtask

    // key held for the first hold_key pixels of line 1
    // dark_cam keeps its de low for the whole frame
    task automatic send_frame(input int hold_key, input int dark_cam);
        frame_sel = cam_id_t'(presses % `CAM_NUM);
        for (int i = 0; i < 4; i++) begin
            drive_cycle(1'b1, 1'b0, 1'b0, 0, 0, 1'b0, dark_cam);
        end
        for (int i = 0; i < 2; i++) begin
            drive_cycle(1'b0, 1'b0, 1'b0, 0, 0, 1'b0, dark_cam);
        end
        for (int ln = 0; ln < LINES; ln++) begin
            for (int px = 0; px < PIXW; px++) begin
                drive_cycle(1'b0, 1'b0, 1'b1, px, ln, (ln == 1) && (px < hold_key), dark_cam);
            end
            for (int b = 0; b < 6; b++) begin
                drive_cycle(1'b0, (b == 1) || (b == 2), 1'b0, 0, ln, 1'b0, dark_cam);
            end
        end
        if (hold_key >= `KEY_TICK) presses++;
    endtask

    task automatic wait_output_idle();
        int n;
        n = 0;
        @(negedge main_clk);
        while (o_pix.de || o_pix.vsync) begin
            @(negedge main_clk);
            n++;
            if (n > 100) begin
                $display("Simulation failed");
                $fatal(1, "output never went idle after the last frame");
            end
        end
    endtask

    // ************************************************************
    // directed tests
    // ************************************************************
    task automatic test_reset();
        test_name = "reset";
        for (int i = 0; i < 4; i++) begin
            @(negedge main_clk);
            check_pix('0, o_pix);
        end
        @(posedge main_clk);
        rstn <= 1'b1;
        @(negedge main_clk);
        check_pix('0, o_pix);
        mon_on = 1'b1;
    endtask

    task automatic test_passthrough();
        test_name = "passthrough";
        send_frame(0, -1);
        send_frame(0, -1);
    endtask

    task automatic test_bounce();
        test_name = "bounce";
        send_frame(`KEY_TICK - 1, -1);
        send_frame(1, -1);
        send_frame(0, -1);
    endtask

    task automatic test_wrap();
        test_name = "wrap";
        for (int i = 0; i < `CAM_NUM; i++) begin
            send_frame(`KEY_TICK, -1);   // visits 1, 2, 3 then 0
        end
        send_frame(0, -1);
    endtask

    task automatic test_switch();
        test_name = "switch";
        send_frame(`KEY_TICK + 1, -1);   // rest of this frame stays on camera 0
        send_frame(0, -1);
    endtask

    task automatic test_empty_lane();
        test_name = "empty_lane";
        send_frame(0, int'(frame_sel));
        send_frame(0, -1);
    endtask

    initial begin
        void'($urandom(11));
        rstn      <= 1'b0;
        i_key     <= 1'b0;
        mon_on    = 1'b0;
        fill      = 0;
        presses   = 0;
        frame_sel = '0;
        tag_sel   <= '0;
        tag_dark  <= 1'b0;
        for (int j = 0; j < `CAM_NUM; j++) begin
            cam_pix[j] <= '0;
        end
        test_reset();
        test_passthrough();
        test_bounce();
        test_wrap();
        test_switch();
        test_empty_lane();
        wait_output_idle();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule : tb_cam_switch

`default_nettype wire

// File: video_pkg.sv
`default_nettype none

`include "cam_switch_config.svh"

package video_pkg;

    localparam int X_W   = $clog2(`H_ACT);
    localparam int Y_W   = $clog2(`V_ACT);
    localparam int CAM_W = (`CAM_NUM > 1) ? $clog2(`CAM_NUM) : 1;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        logic           hsync;
        logic           vsync;
        logic           de;
        rgb_t           rgb;
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
    } pixel_t;

    typedef logic [CAM_W-1:0] cam_id_t;

    typedef enum logic [1:0] {
        KEY_IDLE,         // released and stable
        KEY_PRESS_WAIT,   // going high, not yet stable
        KEY_HELD,         // pressed and stable
        KEY_RELEASE_WAIT  // going low, not yet stable
    } key_state_t;

endpackage : video_pkg

`default_nettype wire
